// File: logic/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    // serial bus timing, one SCL bit is four quarters
    localparam int QUARTER_CLKS = 4;
    localparam int QCNT_W = $clog2(QUARTER_CLKS);
    localparam logic [QCNT_W-1:0] QCNT_LAST = QCNT_W'(QUARTER_CLKS - 1);

    localparam int ADDR_W = 11;
    localparam logic [3:0] DEVICE_CODE = 4'b1010;   // 24Cxx family code

    typedef enum logic {
        OP_WRITE,
        OP_READ
    } eeprom_op_e;

    typedef struct packed {
        eeprom_op_e        op;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        wdata;
    } eeprom_req_t;

    typedef struct packed {
        eeprom_op_e op;
        logic [7:0] rdata;
        logic       nack;
    } eeprom_rsp_t;

    typedef enum logic [1:0] {
        PHY_START,
        PHY_STOP,
        PHY_WRITE_BYTE,
        PHY_READ_BYTE
    } phy_kind_e;

    typedef struct packed {
        phy_kind_e  kind;
        logic [7:0] data;
        logic       ack_send;   // 1 drives ACK low on a read byte
    } phy_cmd_t;

    typedef struct packed {
        logic [7:0] data;
        logic       ack_seen;
    } phy_result_t;

    typedef enum logic [3:0] {
        IDLE,
        START,
        CTRL_WR,
        ADDR,
        DATA_WR,
        RESTART,
        CTRL_RD,
        DATA_RD,
        STOP,
        RESPOND
    } seq_state_e;

endpackage

`default_nettype wire

// File: logic/serial_bit_engine.sv
`default_nettype none

module serial_bit_engine
    import eeprom_pkg::*;
(
    input  wire logic        CLK,
    input  wire logic        RESET,
    input  wire logic        cmd_valid,
    input  wire phy_cmd_t    cmd,
    output logic             cmd_ready,
    output logic             done_valid,
    output phy_result_t      done,
    output logic             scl,
    output logic             sda_low,
    input  wire logic        sda_in
);

    typedef enum logic [1:0] {
        ENG_IDLE,
        ENG_PREP,
        ENG_RUN
    } eng_state_e;

    eng_state_e        state;
    phy_kind_e         kind;
    logic              ack_send;
    logic [7:0]        shreg;
    logic [QCNT_W-1:0] qcnt;
    logic [1:0]        qidx;
    logic [3:0]        bitcnt;
    logic [3:0]        last_bit;
    logic              rx_bit;
    logic              scl_lvl;
    logic              sda_lvl;
    logic              bit_end;

    assign cmd_ready = (state == ENG_IDLE);

    // start and stop are a single bit slot, bytes carry the ack as ninth bit
    assign last_bit = (kind == PHY_START || kind == PHY_STOP) ? 4'd0 : 4'd8;
    assign bit_end  = (qcnt == QCNT_LAST) && (qidx == 2'd3);

    // line levels wanted for the current quarter
    always_comb
    begin
        scl_lvl = scl;
        sda_lvl = sda_low;
        case (kind)
            PHY_START:
            begin
                // q0 hold scl, release sda; q2 sda falls with scl high
                scl_lvl = (qidx == 2'd0) ? scl : (qidx != 2'd3);
                sda_lvl = qidx[1];
            end
            PHY_STOP:
            begin
                scl_lvl = (qidx != 2'd0);
                sda_lvl = (qidx != 2'd3);    // sda rises last, scl high
            end
            PHY_WRITE_BYTE:
            begin
                scl_lvl = qidx[0] ^ qidx[1];
                sda_lvl = (bitcnt == 4'd8) ? 1'b0 : ~shreg[7];  // let go for slave ack
            end
            PHY_READ_BYTE:
            begin
                scl_lvl = qidx[0] ^ qidx[1];
                sda_lvl = (bitcnt == 4'd8) ? ack_send : 1'b0;
            end
            default:
            begin
                scl_lvl = scl;
                sda_lvl = sda_low;
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state      <= ENG_IDLE;
            qcnt       <= '0;
            qidx       <= 2'd0;
            bitcnt     <= 4'd0;
            scl        <= 1'b1;         // bus released
            sda_low    <= 1'b0;
            done_valid <= 1'b0;
        end
        else
        begin
            done_valid <= 1'b0;
            case (state)
                ENG_IDLE:
                begin
                    if (cmd_valid)
                    begin
                        state <= ENG_PREP;
                    end
                end
                ENG_PREP:
                begin
                    state  <= ENG_RUN;
                    qcnt   <= '0;
                    qidx   <= 2'd0;
                    bitcnt <= 4'd0;
                end
                ENG_RUN:
                begin
                    scl     <= scl_lvl;
                    sda_low <= sda_lvl;
                    if (qcnt == QCNT_LAST)
                    begin
                        qcnt <= '0;
                        qidx <= qidx + 2'd1;
                    end
                    else
                    begin
                        qcnt <= qcnt + 1'b1;
                    end
                    if (bit_end)
                    begin
                        if (bitcnt == last_bit)
                        begin
                            state      <= ENG_IDLE;
                            done_valid <= 1'b1;
                        end
                        else
                        begin
                            bitcnt <= bitcnt + 4'd1;
                        end
                    end
                end
                default:
                begin
                    state <= ENG_IDLE;
                end
            endcase
        end
    end

    // command capture, shifter and sampling
    always_ff @(posedge CLK)
    begin
        if (state == ENG_IDLE && cmd_valid)
        begin
            kind     <= cmd.kind;
            shreg    <= cmd.data;
            ack_send <= cmd.ack_send;
        end
        if (state == ENG_RUN)
        begin
            if (qidx == 2'd2 && qcnt == '0)
            begin
                rx_bit <= sda_in;       // middle of scl high
            end
            if (bit_end && bitcnt != last_bit)
            begin
                shreg <= {shreg[6:0], rx_bit};
            end
            if (bit_end && bitcnt == last_bit)
            begin
                done.data     <= shreg;
                done.ack_seen <= ~rx_bit;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/eeprom_sequencer.sv
`default_nettype none

module eeprom_sequencer
    import eeprom_pkg::*;
(
    input  wire logic        CLK,
    input  wire logic        RESET,
    input  wire logic        req_valid,
    output logic             req_ready,
    input  wire eeprom_req_t req,
    output logic             rsp_valid,
    input  wire logic        rsp_ready,
    output eeprom_rsp_t      rsp,
    output logic             cmd_valid,
    input  wire logic        cmd_ready,
    output phy_cmd_t         cmd,
    input  wire logic        done_valid,
    input  wire phy_result_t done
);

    seq_state_e  state;
    eeprom_req_t req_q;
    logic        issued;        // command handed to engine, waiting for done
    logic        nack_q;
    logic [7:0]  rdata_q;
    logic        cmd_state;

    assign cmd_state = (state != IDLE) && (state != RESPOND);
    assign cmd_valid = cmd_state && !issued;
    assign rsp_valid = (state == RESPOND);

    assign rsp.op    = req_q.op;
    assign rsp.rdata = rdata_q;
    assign rsp.nack  = nack_q;

    // engine command for the current step
    always_comb
    begin
        cmd.kind     = PHY_START;
        cmd.data     = 8'h00;
        cmd.ack_send = 1'b0;
        case (state)
            CTRL_WR:
            begin
                cmd.kind = PHY_WRITE_BYTE;
                cmd.data = {DEVICE_CODE, req_q.addr[ADDR_W-1:8], 1'b0};
            end
            ADDR:
            begin
                cmd.kind = PHY_WRITE_BYTE;
                cmd.data = req_q.addr[7:0];
            end
            DATA_WR:
            begin
                cmd.kind = PHY_WRITE_BYTE;
                cmd.data = req_q.wdata;
            end
            CTRL_RD:
            begin
                cmd.kind = PHY_WRITE_BYTE;
                cmd.data = {DEVICE_CODE, req_q.addr[ADDR_W-1:8], 1'b1};
            end
            DATA_RD:
            begin
                cmd.kind     = PHY_READ_BYTE;
                cmd.ack_send = 1'b0;    // single byte, end with NACK
            end
            STOP:
            begin
                cmd.kind = PHY_STOP;
            end
            default:
            begin
                cmd.kind = PHY_START;
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= IDLE;
            issued    <= 1'b0;
            req_ready <= 1'b0;
            nack_q    <= 1'b0;
        end
        else
        begin
            if (cmd_valid && cmd_ready)
            begin
                issued <= 1'b1;
            end
            if (done_valid)
            begin
                issued <= 1'b0;
            end
            case (state)
                IDLE:
                begin
                    if (req_valid && req_ready)
                    begin
                        req_ready <= 1'b0;
                        nack_q    <= 1'b0;
                        state     <= START;
                    end
                    else
                    begin
                        req_ready <= 1'b1;
                    end
                end
                START:
                begin
                    if (done_valid)
                    begin
                        state <= CTRL_WR;
                    end
                end
                CTRL_WR, ADDR, DATA_WR, CTRL_RD:
                begin
                    if (done_valid)
                    begin
                        if (!done.ack_seen)
                        begin
                            nack_q <= 1'b1;     // slave refused, wrap up
                            state  <= STOP;
                        end
                        else if (state == CTRL_WR)
                        begin
                            state <= ADDR;
                        end
                        else if (state == ADDR)
                        begin
                            state <= (req_q.op == OP_READ) ? RESTART : DATA_WR;
                        end
                        else if (state == CTRL_RD)
                        begin
                            state <= DATA_RD;
                        end
                        else
                        begin
                            state <= STOP;
                        end
                    end
                end
                RESTART:
                begin
                    if (done_valid)
                    begin
                        state <= CTRL_RD;
                    end
                end
                DATA_RD:
                begin
                    if (done_valid)
                    begin
                        state <= STOP;
                    end
                end
                STOP:
                begin
                    if (done_valid)
                    begin
                        state <= RESPOND;
                    end
                end
                RESPOND:
                begin
                    if (rsp_ready)
                    begin
                        state     <= IDLE;
                        req_ready <= 1'b1;
                    end
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == IDLE && req_valid && req_ready)
        begin
            req_q   <= req;
            rdata_q <= 8'h00;   // stays zero unless a byte is read
        end
        if (state == DATA_RD && done_valid)
        begin
            rdata_q <= done.data;
        end
    end

endmodule

`default_nettype wire

// File: logic/eeprom_master_top.sv
`default_nettype none

module eeprom_master_top
    import eeprom_pkg::*;
(
    input  wire logic        CLK,
    input  wire logic        RESET,
    input  wire logic        req_valid,
    output logic             req_ready,
    input  wire eeprom_req_t req,
    output logic             rsp_valid,
    input  wire logic        rsp_ready,
    output eeprom_rsp_t      rsp,
    output logic             scl,
    output logic             sda_low,
    input  wire logic        sda_in
);

    logic        cmd_valid;
    logic        cmd_ready;
    phy_cmd_t    cmd;
    logic        done_valid;
    phy_result_t done;

    // transaction level
    eeprom_sequencer i_eeprom_sequencer (
        .CLK        (CLK),
        .RESET      (RESET),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp        (rsp),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd        (cmd),
        .done_valid (done_valid),
        .done       (done)
    );

    // bus level, drives the pins
    serial_bit_engine i_serial_bit_engine (
        .CLK        (CLK),
        .RESET      (RESET),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cmd_ready  (cmd_ready),
        .done_valid (done_valid),
        .done       (done),
        .scl        (scl),
        .sda_low    (sda_low),
        .sda_in     (sda_in)
    );

endmodule

`default_nettype wire

// File: sim/eeprom_slave_model.sv
`default_nettype none

module eeprom_slave_model (
    input  wire logic scl,
    input  wire logic sda,
    input  wire logic wp,
    output logic      sda_low
);

    typedef enum int {
        P_IDLE,
        P_CTRL,
        P_ADDR,
        P_DATA,
        P_READ
    } phase_e;

    logic [7:0]  mem [0:2047];
    phase_e      phase = P_IDLE;
    phase_e      next_phase = P_IDLE;
    int          bit_cnt = 0;          // scl rising edges within the current byte
    logic [7:0]  shift = 8'h00;
    logic [7:0]  rd_byte = 8'h00;
    logic [10:0] ptr = 11'h000;
    logic        ack;

    function automatic logic [7:0] preset_byte(input logic [10:0] a);
        return a[7:0] ^ 8'h5a ^ {a[10:8], 5'b00000};
    endfunction

    initial
    begin
        int a;
        sda_low = 1'b0;
        for (a = 0; a < 2048; a++)
            mem[a] = preset_byte(11'(a));
    end

    // start and stop are sda edges while scl is high
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            phase   = P_CTRL;
            bit_cnt = 0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1)
            phase = P_IDLE;
    end

    always @(posedge scl)
    begin
        if (phase != P_IDLE)
        begin
            if (bit_cnt < 8)
                shift = {shift[6:0], sda};
            bit_cnt = bit_cnt + 1;
        end
    end

    // slave only changes sda while scl is low
    always @(negedge scl)
    begin
        if (phase != P_IDLE && phase != P_READ && bit_cnt == 8)
        begin
            ack = 1'b1;
            case (phase)
                P_CTRL:
                begin
                    ack        = (shift[7:4] == 4'b1010);
                    ptr[10:8]  = shift[3:1];
                    next_phase = shift[0] ? P_READ : P_ADDR;
                end
                P_ADDR:
                begin
                    ptr[7:0]   = shift;
                    next_phase = P_DATA;
                end
                default:
                begin
                    ack = !wp;
                    if (!wp)
                        mem[ptr] = shift;   // write cycle takes no time here
                    next_phase = P_IDLE;
                end
            endcase
            if (!ack)
                next_phase = P_IDLE;
            sda_low = ack;
        end
        else if (phase != P_IDLE && bit_cnt == 9)
        begin
            sda_low    = 1'b0;
            bit_cnt    = 0;
            phase      = next_phase;
            next_phase = P_IDLE;     // single byte read, then wait for stop
            if (phase == P_READ)
                rd_byte = mem[ptr];
        end
        if (phase == P_READ)
            sda_low = (bit_cnt < 8) ? ~rd_byte[7 - bit_cnt] : 1'b0;
    end

endmodule

`default_nettype wire

// File: sim/eeprom_check.sv
`default_nettype none

module eeprom_check
    import eeprom_pkg::*;
(
    input  wire logic        CLK,
    input  wire logic        RESET,
    input  wire logic        req_valid,
    input  wire logic        req_ready,
    input  wire eeprom_req_t req,
    input  wire logic        rsp_valid,
    input  wire logic        rsp_ready,
    input  wire eeprom_rsp_t rsp,
    input  wire logic        scl,
    input  wire logic        sda_low,
    input  wire logic        wp,
    output int               test_count,
    output int               error_count
);

    logic [7:0]        ref_mem [0:2047];
    eeprom_rsp_t       expect_q [$];
    logic [ADDR_W-1:0] addr_q [$];
    logic              started = 1'b0;
    logic              idle_bad = 1'b0;
    int                idle_cycles = 0;
    int                tests = 0;
    int                errors = 0;

    assign test_count  = tests;
    assign error_count = errors;

    function automatic logic [7:0] preset_byte(input logic [ADDR_W-1:0] a);
        return a[7:0] ^ 8'h5a ^ {a[10:8], 5'b00000};
    endfunction

    function automatic string op_text(input eeprom_op_e op);
        return (op == OP_READ) ? "read" : "write";
    endfunction

    task automatic report_value(input string name, input logic [7:0] got,
                                input logic [7:0] want);
        $display("Error: %s is 0x%02h, expected 0x%02h", name, got, want);
        errors++;
    endtask

    initial
    begin
        int a;
        for (a = 0; a < 2048; a++)
            ref_mem[a] = preset_byte(ADDR_W'(a));
    end

    always @(posedge CLK)
    begin
        eeprom_rsp_t       want;
        logic [ADDR_W-1:0] addr;
        logic              bad;
        logic              ready_want;
        if (!RESET)
        begin
            // bus must stay released until the first request
            if (!started && !idle_bad)
            begin
                ready_want = (idle_cycles != 0);   // up one cycle after reset
                if (req_ready !== ready_want)
                    report_value("req_ready", {7'b0, req_ready}, {7'b0, ready_want});
                if (rsp_valid !== 1'b0)
                    report_value("rsp_valid", {7'b0, rsp_valid}, 8'h00);
                if (scl !== 1'b1)
                    report_value("scl", {7'b0, scl}, 8'h01);
                if (sda_low !== 1'b0)
                    report_value("sda_low", {7'b0, sda_low}, 8'h00);
                idle_bad = (errors != 0);
                idle_cycles++;
            end
            if (req_ready && expect_q.size() != 0)
            begin
                $display("req_ready is high while a response is still pending");
                errors++;
            end
            if (rsp_valid && rsp_ready)
            begin
                if (expect_q.size() == 0)
                begin
                    $display("a response arrived with no request outstanding");
                    errors++;
                end
                else
                begin
                    want = expect_q.pop_front();
                    addr = addr_q.pop_front();
                    bad  = 1'b0;
                    if (rsp.op !== want.op)
                    begin
                        $display("response is for a %s but the request was a %s",
                                 op_text(rsp.op), op_text(want.op));
                        errors++;
                        bad = 1'b1;
                    end
                    if (rsp.rdata !== want.rdata)
                    begin
                        report_value("rsp.rdata", rsp.rdata, want.rdata);
                        bad = 1'b1;
                    end
                    if (rsp.nack !== want.nack)
                    begin
                        report_value("rsp.nack", {7'b0, rsp.nack}, {7'b0, want.nack});
                        bad = 1'b1;
                    end
                    tests++;
                    $display("test %0d: %s at 0x%03h, rdata 0x%02h nack %0d, %s", tests,
                             op_text(want.op), addr, rsp.rdata, rsp.nack,
                             bad ? "mismatch" : "pass");
                end
            end
            if (req_valid && req_ready)
            begin
                if (!started)
                begin
                    started = 1'b1;
                    tests++;
                    $display("test %0d: bus idle after reset, %s", tests,
                             idle_bad ? "mismatch" : "pass");
                end
                want.op    = req.op;
                want.rdata = 8'h00;
                want.nack  = 1'b0;
                if (req.op == OP_READ)
                    want.rdata = ref_mem[req.addr];
                else if (wp)
                    want.nack = 1'b1;           // protected write leaves memory as it was
                else
                    ref_mem[req.addr] = req.wdata;
                expect_q.push_back(want);
                addr_q.push_back(req.addr);
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_eeprom.sv
`default_nettype none

module tb_eeprom
    import eeprom_pkg::*;
();

    localparam int READS_PRESET = 12;
    localparam int WRITES       = 16;
    localparam int READS_RANDOM = 8;
    localparam int PROTECTED    = 8;
    localparam int TXN_COUNT    = READS_PRESET + 2 * WRITES + READS_RANDOM + 2 * PROTECTED + 3;
    localparam int CYCLE_LIMIT  = TXN_COUNT * 800 + 100;

    logic              CLK = 1'b0;
    logic              RESET;
    logic              req_valid;
    logic              req_ready;
    eeprom_req_t       req;
    logic              rsp_valid;
    logic              rsp_ready;
    eeprom_rsp_t       rsp;
    logic              scl;
    logic              dut_sda_low;
    logic              slave_sda_low;
    logic              sda;
    logic              wp;
    int                cycles = 0;
    int                test_count;
    int                error_count;
    logic [ADDR_W-1:0] written [$];

    always #5 CLK = ~CLK;

    assign sda = !(dut_sda_low || slave_sda_low);  // pull-up, either side pulls low

    eeprom_master_top i_eeprom_master_top (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp),
        .scl       (scl),
        .sda_low   (dut_sda_low),
        .sda_in    (sda)
    );

    eeprom_slave_model i_eeprom_slave_model (
        .scl     (scl),
        .sda     (sda),
        .wp      (wp),
        .sda_low (slave_sda_low)
    );

    eeprom_check i_eeprom_check (
        .CLK         (CLK),
        .RESET       (RESET),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req         (req),
        .rsp_valid   (rsp_valid),
        .rsp_ready   (rsp_ready),
        .rsp         (rsp),
        .scl         (scl),
        .sda_low     (dut_sda_low),
        .wp          (wp),
        .test_count  (test_count),
        .error_count (error_count)
    );

    function automatic logic [ADDR_W-1:0] random_addr();
        return ADDR_W'($urandom);
    endfunction

    task automatic issue_request(input eeprom_op_e op, input logic [ADDR_W-1:0] addr,
                                 input logic [7:0] wdata);
        repeat ($urandom_range(0, 6)) @(posedge CLK);
        @(posedge CLK);
        #1;
        req_valid = 1'b1;
        req.op    = op;
        req.addr  = addr;
        req.wdata = wdata;
        do
            @(posedge CLK);
        while (!req_ready);
        #1;
        req_valid = 1'b0;
    endtask

    // back at idle once the pending response was taken
    task automatic wait_until_idle();
        do
            @(posedge CLK);
        while (!req_ready);
        #1;
    endtask

    initial
    begin
        rsp_ready = 1'b0;
        @(negedge RESET);
        forever
        begin
            repeat ($urandom_range(1, rsp_ready ? 6 : 24)) @(posedge CLK);
            #1;
            rsp_ready = ~rsp_ready;
        end
    end

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Something failed");
            $finish;
        end
    end

    initial
    begin
        int i;
        RESET     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        wp        = 1'b0;
        void'($urandom(32'h65fb_0ce2));
        repeat (16) @(posedge CLK);
        #1;
        RESET = 1'b0;
        repeat (READS_PRESET)
            issue_request(OP_READ, random_addr(), 8'h00);
        for (i = 0; i < WRITES; i++)
        begin
            written.push_back(random_addr());
            issue_request(OP_WRITE, written[i], 8'($urandom));
        end
        foreach (written[j])
            issue_request(OP_READ, written[j], 8'h00);
        repeat (READS_RANDOM)
            issue_request(OP_READ, random_addr(), 8'h00);
        issue_request(OP_WRITE, 11'h7c3, 8'h3c);    // same low byte, top and bottom block
        issue_request(OP_READ, 11'h0c3, 8'h00);
        issue_request(OP_READ, 11'h7c3, 8'h00);
        wait_until_idle();
        wp = 1'b1;
        written.delete();
        for (i = 0; i < PROTECTED; i++)
        begin
            written.push_back(random_addr());
            issue_request(OP_WRITE, written[i], 8'($urandom));
        end
        wait_until_idle();
        wp = 1'b0;
        foreach (written[j])
            issue_request(OP_READ, written[j], 8'h00);
        wait_until_idle();
        repeat (4) @(posedge CLK);
        if (test_count != TXN_COUNT + 1)
            $display("expected %0d tests to finish, saw %0d", TXN_COUNT + 1, test_count);
        $display("%0d tests finished, %0d errors", test_count, error_count);
        if (error_count == 0 && test_count == TXN_COUNT + 1)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
logic/eeprom_pkg.sv
logic/serial_bit_engine.sv
logic/eeprom_sequencer.sv
logic/eeprom_master_top.sv
sim/eeprom_slave_model.sv
sim/eeprom_check.sv
sim/tb_eeprom.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_eeprom -f list.f -o sim_eeprom
./obj_dir/sim_eeprom > sim.log 2>&1
cat sim.log

if grep -q "Something failed" sim.log
then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failures"
